// File: design/xgmii_pkg.sv
package xgmii_pkg;

    // 64-bit XGMII transmit word, eight byte lanes
    localparam int XGMII_DATA_W = 64;
    localparam int XGMII_LANES  = 8;

    // Width of the frame and gap byte counters
    localparam int FRAME_LEN_W = 16;

    typedef logic [2:0] lane_idx_t;

    // Control characters carried on lanes with the control bit set
    typedef enum logic [7:0] {
        CODE_IDLE  = 8'h07,
        CODE_START = 8'hFB,
        CODE_TERM  = 8'hFD,
        CODE_ERROR = 8'hFE
    } xgmii_code_t;

    // Default check limits, in bytes
    localparam int DEF_MIN_FRAME = 64;
    localparam int DEF_MAX_FRAME = 1518;
    localparam int DEF_MIN_IPG   = 12;

    localparam int DEF_CNT_W = 16; // Statistics counter width

endpackage

// File: design/xgmii_lane_decoder.sv
`timescale 1ns/100ps

module xgmii_lane_decoder (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [xgmii_pkg::XGMII_DATA_W-1:0] i_txd,
    input  logic [xgmii_pkg::XGMII_LANES-1:0]  i_txc,
    output logic                               o_start,
    output logic                               o_term,
    output xgmii_pkg::lane_idx_t               o_term_lane,
    output logic                               o_idle_word,
    output logic                               o_tail_bad,
    output logic                               o_data_ctrl,
    output logic                               o_misplaced_start
);
    import xgmii_pkg::*;

    logic [XGMII_LANES-1:0] is_idle;
    logic [XGMII_LANES-1:0] is_term;
    logic [XGMII_LANES-1:0] is_start;
    logic                   term_c;
    lane_idx_t              term_lane_c;
    logic                   tail_bad_c;
    logic                   data_ctrl_c;

    // Per-lane control character match
    always_comb begin
        for (int k = 0; k < XGMII_LANES; k++) begin
            is_idle[k]  = i_txc[k] && (i_txd[8*k +: 8] == CODE_IDLE);
            is_term[k]  = i_txc[k] && (i_txd[8*k +: 8] == CODE_TERM);
            is_start[k] = i_txc[k] && (i_txd[8*k +: 8] == CODE_START);
        end
    end

    // Priority search, lowest terminate lane wins
    always_comb begin
        term_c      = 1'b0;
        term_lane_c = '0;
        for (int k = XGMII_LANES - 1; k >= 0; k--) begin
            if (is_term[k]) begin
                term_c      = 1'b1;
                term_lane_c = lane_idx_t'(k);
            end
        end
    end

    always_comb begin
        tail_bad_c  = 1'b0;
        data_ctrl_c = 1'b0;
        for (int k = 0; k < XGMII_LANES; k++) begin
            // Lanes after the terminate must be idle
            if (term_c && (k > int'(term_lane_c)) && !is_idle[k]) begin
                tail_bad_c = 1'b1;
            end
            // Data lanes carry no control, start in lane 0 excepted
            if ((!term_c || (k < int'(term_lane_c))) && i_txc[k] &&
                !((k == 0) && is_start[0])) begin
                data_ctrl_c = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start           <= 1'b0;
            o_term            <= 1'b0;
            o_term_lane       <= '0;
            o_idle_word       <= 1'b0;
            o_tail_bad        <= 1'b0;
            o_data_ctrl       <= 1'b0;
            o_misplaced_start <= 1'b0;
        end else begin
            o_start           <= is_start[0];
            o_term            <= term_c;
            o_term_lane       <= term_lane_c;
            o_idle_word       <= &is_idle;
            o_tail_bad        <= tail_bad_c;
            o_data_ctrl       <= data_ctrl_c;
            o_misplaced_start <= |is_start[XGMII_LANES-1:1];
        end
    end

endmodule

// File: design/xgmii_frame_checker.sv
`timescale 1ns/100ps

module xgmii_frame_checker #(
    parameter int MIN_FRAME = xgmii_pkg::DEF_MIN_FRAME,
    parameter int MAX_FRAME = xgmii_pkg::DEF_MAX_FRAME,
    parameter int MIN_IPG   = xgmii_pkg::DEF_MIN_IPG
) (
    input  logic                              clk,
    input  logic                              i_rst_n,
    input  logic                              i_start,
    input  logic                              i_term,
    input  xgmii_pkg::lane_idx_t              i_term_lane,
    input  logic                              i_idle_word,
    input  logic                              i_tail_bad,
    input  logic                              i_data_ctrl,
    input  logic                              i_misplaced_start,
    output logic                              o_frame_ok,
    output logic                              o_len_err,
    output logic                              o_ipg_err,
    output logic                              o_code_err,
    output logic [xgmii_pkg::FRAME_LEN_W-1:0] o_frame_len
);
    import xgmii_pkg::*;

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_FRAME,
        ST_GAP
    } chk_state_t;

    localparam logic [FRAME_LEN_W-1:0] CNT_MAX = '1;

    chk_state_t             state, state_nxt;
    logic [FRAME_LEN_W-1:0] frame_cnt, frame_cnt_nxt;
    logic [FRAME_LEN_W-1:0] gap_cnt, gap_cnt_nxt;
    logic                   code_hold, code_hold_nxt;
    logic [FRAME_LEN_W-1:0] len_c;
    logic [FRAME_LEN_W-1:0] frame_len_nxt;
    logic                   len_bad;
    logic                   start_word_err;
    logic                   frame_word_err;
    logic                   term_err;
    logic                   frame_ok_nxt;
    logic                   len_err_nxt;
    logic                   ipg_err_nxt;
    logic                   code_err_nxt;

    function automatic logic [FRAME_LEN_W-1:0] sat_add(
        input logic [FRAME_LEN_W-1:0] a,
        input logic [3:0]             b
    );
        logic [FRAME_LEN_W:0] sum;
        sum = {1'b0, a} + b;
        return sum[FRAME_LEN_W] ? CNT_MAX : sum[FRAME_LEN_W-1:0];
    endfunction

    assign len_c   = sat_add(frame_cnt, {1'b0, i_term_lane}); // Bytes before the terminate
    assign len_bad = (int'(len_c) < MIN_FRAME) || (int'(len_c) > MAX_FRAME);

    assign start_word_err = i_data_ctrl | i_misplaced_start;
    assign frame_word_err = start_word_err | i_start; // A second start inside a frame
    assign term_err       = code_hold | frame_word_err | i_tail_bad;

    always_comb begin
        state_nxt     = state;
        frame_cnt_nxt = frame_cnt;
        gap_cnt_nxt   = gap_cnt;
        code_hold_nxt = code_hold;
        frame_len_nxt = o_frame_len;
        frame_ok_nxt  = 1'b0;
        len_err_nxt   = 1'b0;
        ipg_err_nxt   = 1'b0;
        code_err_nxt  = 1'b0;

        case (state)
            ST_WAIT: begin
                if (i_start) begin
                    state_nxt     = ST_FRAME;
                    frame_cnt_nxt = FRAME_LEN_W'(7);
                    code_hold_nxt = start_word_err;
                end else if (i_misplaced_start) begin
                    code_err_nxt = 1'b1;
                end
            end

            ST_FRAME: begin
                if (i_term) begin
                    state_nxt     = ST_GAP;
                    gap_cnt_nxt   = FRAME_LEN_W'(3'd7 - i_term_lane);
                    frame_len_nxt = len_c;
                    len_err_nxt   = len_bad;
                    code_err_nxt  = term_err;
                    frame_ok_nxt  = !len_bad && !term_err;
                end else begin
                    frame_cnt_nxt = sat_add(frame_cnt, 4'd8);
                    code_hold_nxt = code_hold | frame_word_err; // Held until the terminate
                end
            end

            ST_GAP: begin
                if (i_start) begin
                    state_nxt     = ST_FRAME;
                    frame_cnt_nxt = FRAME_LEN_W'(7);
                    code_hold_nxt = start_word_err;
                    ipg_err_nxt   = int'(gap_cnt) < MIN_IPG;
                end else begin
                    gap_cnt_nxt  = sat_add(gap_cnt, 4'd8);
                    code_err_nxt = !i_idle_word; // Only idle or start is legal here
                end
            end

            default: state_nxt = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_WAIT;
            frame_cnt   <= '0;
            gap_cnt     <= '0;
            code_hold   <= 1'b0;
            o_frame_len <= '0;
            o_frame_ok  <= 1'b0;
            o_len_err   <= 1'b0;
            o_ipg_err   <= 1'b0;
            o_code_err  <= 1'b0;
        end else begin
            state       <= state_nxt;
            frame_cnt   <= frame_cnt_nxt;
            gap_cnt     <= gap_cnt_nxt;
            code_hold   <= code_hold_nxt;
            o_frame_len <= frame_len_nxt;
            o_frame_ok  <= frame_ok_nxt;
            o_len_err   <= len_err_nxt;
            o_ipg_err   <= ipg_err_nxt;
            o_code_err  <= code_err_nxt;
        end
    end

endmodule

// File: design/xgmii_error_stats.sv
`timescale 1ns/100ps

module xgmii_error_stats #(
    parameter int CNT_W = xgmii_pkg::DEF_CNT_W
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_clr_stats,
    input  logic             i_frame_ok,
    input  logic             i_len_err,
    input  logic             i_ipg_err,
    input  logic             i_code_err,
    output logic [CNT_W-1:0] o_cnt_frames,
    output logic [CNT_W-1:0] o_cnt_len_err,
    output logic [CNT_W-1:0] o_cnt_ipg_err,
    output logic [CNT_W-1:0] o_cnt_code_err
);

    localparam int N_CNT = 4;

    logic [N_CNT-1:0]            inc;
    logic [N_CNT-1:0][CNT_W-1:0] cnt;

    assign inc = {i_code_err, i_ipg_err, i_len_err, i_frame_ok};

    // Clear wins over an increment in the same cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (i_clr_stats) begin
            cnt <= '0;
        end else begin
            for (int k = 0; k < N_CNT; k++) begin
                if (inc[k] && (cnt[k] != {CNT_W{1'b1}})) begin // Saturate at max
                    cnt[k] <= cnt[k] + 1'b1;
                end
            end
        end
    end

    assign o_cnt_frames   = cnt[0];
    assign o_cnt_len_err  = cnt[1];
    assign o_cnt_ipg_err  = cnt[2];
    assign o_cnt_code_err = cnt[3];

endmodule

// File: design/xgmii_monitor_top.sv
`timescale 1ns/100ps

module xgmii_monitor_top #(
    parameter int MIN_FRAME = xgmii_pkg::DEF_MIN_FRAME,
    parameter int MAX_FRAME = xgmii_pkg::DEF_MAX_FRAME,
    parameter int MIN_IPG   = xgmii_pkg::DEF_MIN_IPG,
    parameter int CNT_W     = xgmii_pkg::DEF_CNT_W
) (
    input  logic                               clk,
    input  logic                               i_rst_n,
    input  logic [xgmii_pkg::XGMII_DATA_W-1:0] i_txd,
    input  logic [xgmii_pkg::XGMII_LANES-1:0]  i_txc,
    input  logic                               i_clr_stats,
    output logic                               o_frame_ok,
    output logic                               o_len_err,
    output logic                               o_ipg_err,
    output logic                               o_code_err,
    output logic [xgmii_pkg::FRAME_LEN_W-1:0]  o_frame_len,
    output logic [CNT_W-1:0]                   o_cnt_frames,
    output logic [CNT_W-1:0]                   o_cnt_len_err,
    output logic [CNT_W-1:0]                   o_cnt_ipg_err,
    output logic [CNT_W-1:0]                   o_cnt_code_err
);
    import xgmii_pkg::*;

    logic      dec_start;
    logic      dec_term;
    lane_idx_t dec_term_lane;
    logic      dec_idle_word;
    logic      dec_tail_bad;
    logic      dec_data_ctrl;
    logic      dec_misplaced_start;

    xgmii_lane_decoder u_decoder (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_txd             (i_txd),
        .i_txc             (i_txc),
        .o_start           (dec_start),
        .o_term            (dec_term),
        .o_term_lane       (dec_term_lane),
        .o_idle_word       (dec_idle_word),
        .o_tail_bad        (dec_tail_bad),
        .o_data_ctrl       (dec_data_ctrl),
        .o_misplaced_start (dec_misplaced_start)
    );

    xgmii_frame_checker #(
        .MIN_FRAME (MIN_FRAME),
        .MAX_FRAME (MAX_FRAME),
        .MIN_IPG   (MIN_IPG)
    ) u_checker (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_start           (dec_start),
        .i_term            (dec_term),
        .i_term_lane       (dec_term_lane),
        .i_idle_word       (dec_idle_word),
        .i_tail_bad        (dec_tail_bad),
        .i_data_ctrl       (dec_data_ctrl),
        .i_misplaced_start (dec_misplaced_start),
        .o_frame_ok        (o_frame_ok),
        .o_len_err         (o_len_err),
        .o_ipg_err         (o_ipg_err),
        .o_code_err        (o_code_err),
        .o_frame_len       (o_frame_len)
    );

    xgmii_error_stats #(
        .CNT_W (CNT_W)
    ) u_stats (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_clr_stats    (i_clr_stats),
        .i_frame_ok     (o_frame_ok),
        .i_len_err      (o_len_err),
        .i_ipg_err      (o_ipg_err),
        .i_code_err     (o_code_err),
        .o_cnt_frames   (o_cnt_frames),
        .o_cnt_len_err  (o_cnt_len_err),
        .o_cnt_ipg_err  (o_cnt_ipg_err),
        .o_cnt_code_err (o_cnt_code_err)
    );

endmodule

// File: tb/xgmii_monitor_assert.sv
`timescale 1ns/100ps

module xgmii_monitor_assert (
    input logic clk,
    input logic i_rst_n,
    input logic i_frame_ok,
    input logic i_len_err,
    input logic i_ipg_err,
    input logic i_code_err
);

    // Length and code errors may come together, frame ok never with either
    a_ok_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_frame_ok && (i_len_err || i_code_err)))
        else $error("frame_ok high together with a frame error");

    a_quiet_in_reset: assert property (@(posedge clk)
        !i_rst_n |-> !(i_frame_ok || i_len_err || i_ipg_err || i_code_err))
        else $error("result pulse high while in reset");

endmodule

bind xgmii_frame_checker xgmii_monitor_assert u_assert (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_frame_ok (o_frame_ok),
    .i_len_err  (o_len_err),
    .i_ipg_err  (o_ipg_err),
    .i_code_err (o_code_err)
);

// File: tb/tb_xgmii_monitor.sv
`timescale 1ns/100ps

module tb_xgmii_monitor;
    import xgmii_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MIN_FRAME  = DEF_MIN_FRAME;
    localparam int MAX_FRAME  = DEF_MAX_FRAME;
    localparam int MIN_IPG    = DEF_MIN_IPG;
    localparam int CNT_W      = DEF_CNT_W;
    localparam int MAX_WORDS  = 1024;
    localparam int N_SEG      = 10;
    localparam logic [XGMII_DATA_W-1:0] IDLE_WORD = {XGMII_LANES{8'(CODE_IDLE)}};

    typedef enum int {INJ_NONE, INJ_TAIL, INJ_CTRL, INJ_START} inj_t;
    typedef struct packed {
        int   len;  // Frame length in bytes
        int   gap;  // Minimum idle bytes before the start
        inj_t inj;
    } seg_t;

    // Terminate lanes 1,7,0,0,4,4,2,3,5,6
    seg_t segs [N_SEG] = '{
        '{64,   8,  INJ_NONE},
        '{1518, 14, INJ_NONE},
        '{63,   12, INJ_NONE},
        '{1519, 12, INJ_NONE},
        '{67,   12, INJ_NONE},
        '{67,   11, INJ_NONE},  // Gap comes out at exactly 11
        '{65,   12, INJ_TAIL},
        '{66,   12, INJ_CTRL},
        '{68,   12, INJ_START},
        '{69,   12, INJ_NONE}
    };

    logic                    clk;
    logic                    i_rst_n;
    logic [XGMII_DATA_W-1:0] i_txd;
    logic [XGMII_LANES-1:0]  i_txc;
    logic                    i_clr_stats;
    logic                    o_frame_ok;
    logic                    o_len_err;
    logic                    o_ipg_err;
    logic                    o_code_err;
    logic [FRAME_LEN_W-1:0]  o_frame_len;
    logic [CNT_W-1:0]        o_cnt_frames;
    logic [CNT_W-1:0]        o_cnt_len_err;
    logic [CNT_W-1:0]        o_cnt_ipg_err;
    logic [CNT_W-1:0]        o_cnt_code_err;

    logic [XGMII_DATA_W-1:0] w_txd  [MAX_WORDS];
    logic [XGMII_LANES-1:0]  w_txc  [MAX_WORDS];
    logic [3:0]              w_exp  [MAX_WORDS]; // {code, ipg, len, ok}
    logic                    w_term [MAX_WORDS];
    logic [FRAME_LEN_W-1:0]  w_flen [MAX_WORDS];
    int   n_words;
    logic built;
    int   exp_frames, exp_len, exp_ipg, exp_code;
    int   n_checks, n_errors;

    xgmii_monitor_top #(
        .MIN_FRAME (MIN_FRAME),
        .MAX_FRAME (MAX_FRAME),
        .MIN_IPG   (MIN_IPG),
        .CNT_W     (CNT_W)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_pulse(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input logic [FRAME_LEN_W-1:0] got,
                             input logic [FRAME_LEN_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t ns: frame_len is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Filler stays below FB so no data byte reads as a control code
    function automatic logic [XGMII_DATA_W-1:0] rand_data();
        logic [XGMII_DATA_W-1:0] d;
        for (int k = 0; k < XGMII_LANES; k++) begin
            d[8*k +: 8] = 8'($urandom % 32'hFB);
        end
        return d;
    endfunction

    task automatic push_word(input logic [XGMII_DATA_W-1:0] d, input logic [XGMII_LANES-1:0] c);
        w_txd[n_words]  = d;
        w_txc[n_words]  = c;
        w_exp[n_words]  = '0;
        w_term[n_words] = 1'b0;
        w_flen[n_words] = '0;
        n_words++;
    endtask

    // Builds the words and the expected results of every segment
    task automatic build_words();
        int tail;
        int t;
        int n_mid;
        int n_idle;
        int gap;
        logic len_bad;
        logic code_bad;
        logic [XGMII_DATA_W-1:0] d;
        logic [XGMII_LANES-1:0]  c;
        n_words = 0;
        tail    = 0;
        for (int s = 0; s < N_SEG; s++) begin
            t      = (segs[s].len - 7) % 8;
            n_mid  = (segs[s].len - 7) / 8;
            n_idle = (segs[s].gap - tail + 7) / 8;
            gap    = tail + 8 * n_idle;
            repeat (n_idle) push_word(IDLE_WORD, '1);

            d      = rand_data();
            d[7:0] = CODE_START;
            push_word(d, 8'h01);
            if ((s > 0) && (gap < MIN_IPG)) begin // No gap rule before the first frame
                w_exp[n_words-1][2] = 1'b1;
                exp_ipg++;
            end

            for (int m = 0; m < n_mid; m++) begin
                d = rand_data();
                c = '0;
                if ((m == 1) && (segs[s].inj == INJ_CTRL)) begin
                    d[23:16] = CODE_ERROR;
                    c[2]     = 1'b1;
                end
                if ((m == 1) && (segs[s].inj == INJ_START)) begin
                    d[31:24] = CODE_START; // Start in lane 3
                    c[3]     = 1'b1;
                end
                push_word(d, c);
            end

            d = rand_data();
            c = '0;
            for (int k = t; k < XGMII_LANES; k++) begin
                d[8*k +: 8] = (k == t) ? 8'(CODE_TERM) : 8'(CODE_IDLE);
                c[k]        = 1'b1;
            end
            if (segs[s].inj == INJ_TAIL) begin
                c[7] = 1'b0; // Data byte after the terminate
            end
            push_word(d, c);

            len_bad  = (segs[s].len < MIN_FRAME) || (segs[s].len > MAX_FRAME);
            code_bad = (segs[s].inj != INJ_NONE);
            w_term[n_words-1] = 1'b1;
            w_flen[n_words-1] = FRAME_LEN_W'(segs[s].len);
            w_exp[n_words-1]  = {code_bad, 1'b0, len_bad, !len_bad && !code_bad};
            exp_frames += int'(!len_bad && !code_bad);
            exp_len    += int'(len_bad);
            exp_code   += int'(code_bad);
            tail = 7 - t;
        end
        repeat (3) push_word(IDLE_WORD, '1);
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_txd       = IDLE_WORD;
        i_txc       = '1;
        i_clr_stats = 1'b0;
        built       = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        exp_frames  = 0;
        exp_len     = 0;
        exp_ipg     = 0;
        exp_code    = 0;
        void'($urandom(18779));
        build_words();
        built = 1'b1;

        repeat (5) @(negedge clk);
        i_rst_n = 1'b1;

        // Pulses show up two clocks after their word
        for (int w = 0; w < n_words + 2; w++) begin
            @(negedge clk);
            if (w < n_words) begin
                i_txd = w_txd[w];
                i_txc = w_txc[w];
            end else begin
                i_txd = IDLE_WORD;
                i_txc = '1;
            end
            if (w >= 2) begin
                check_pulse("frame_ok", o_frame_ok, w_exp[w-2][0]);
                check_pulse("len_err", o_len_err, w_exp[w-2][1]);
                check_pulse("ipg_err", o_ipg_err, w_exp[w-2][2]);
                check_pulse("code_err", o_code_err, w_exp[w-2][3]);
                if (w_term[w-2]) begin
                    check_len(o_frame_len, w_flen[w-2]);
                end
            end
        end

        @(negedge clk);
        check_count("cnt_frames", o_cnt_frames, CNT_W'(exp_frames));
        check_count("cnt_len_err", o_cnt_len_err, CNT_W'(exp_len));
        check_count("cnt_ipg_err", o_cnt_ipg_err, CNT_W'(exp_ipg));
        check_count("cnt_code_err", o_cnt_code_err, CNT_W'(exp_code));

        i_clr_stats = 1'b1;
        @(negedge clk);
        i_clr_stats = 1'b0;
        check_count("cnt_frames", o_cnt_frames, '0);
        check_count("cnt_len_err", o_cnt_len_err, '0);
        check_count("cnt_ipg_err", o_cnt_ipg_err, '0);
        check_count("cnt_code_err", o_cnt_code_err, '0);

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (built);
        #((n_words + 50) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", n_words + 50);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog.f
design/xgmii_pkg.sv
design/xgmii_lane_decoder.sv
design/xgmii_frame_checker.sv
design/xgmii_error_stats.sv
design/xgmii_monitor_top.sv
tb/xgmii_monitor_assert.sv
tb/tb_xgmii_monitor.sv

// File: Makefile
SIM      = verilator
FLAGS    = --timing --assert
TOP      = tb_xgmii_monitor
FILELIST = verilog.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ)/V$(TOP): $(FILELIST)
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FILELIST)

sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)
